/* design/bulls_cows_top.sv */
`timescale 1ns/10ps

module bulls_cows_top #(
    parameter int SCAN_BITS = 20
) (
    input logic clk,
    input logic reset,
    input logic btn_inc,
    input logic btn_next,
    output logic [bulls_pkg::NUM_SLOTS-1:0] anode,
    output bulls_pkg::seg_t seg,
    output logic [bulls_pkg::LED_WIDTH-1:0] led
);
    import bulls_pkg::*;

    logic inc_pulse;
    logic next_pulse;
    logic score_req;
    logic score_valid;
    count_t strikes;
    count_t balls;
    frame_t frame;

    entry_if secret_if ();
    entry_if guess_if ();

    button_edge u_buttons (
        .clk(clk),
        .reset(reset),
        .btn_inc(btn_inc),
        .btn_next(btn_next),
        .inc_pulse(inc_pulse),
        .next_pulse(next_pulse)
    );

    // Both entries see every pulse, only the active one reacts
    code_entry u_secret (
        .clk(clk),
        .reset(reset),
        .inc_pulse(inc_pulse),
        .next_pulse(next_pulse),
        .bus(secret_if.entry)
    );

    code_entry u_guess (
        .clk(clk),
        .reset(reset),
        .inc_pulse(inc_pulse),
        .next_pulse(next_pulse),
        .bus(guess_if.entry)
    );

    guess_scorer u_scorer (
        .clk(clk),
        .reset(reset),
        .secret(secret_if.code),
        .guess(guess_if.code),
        .score_req(score_req),
        .score_valid(score_valid),
        .strikes(strikes),
        .balls(balls)
    );

    game_ctrl u_ctrl (
        .clk(clk),
        .reset(reset),
        .secret_bus(secret_if.ctrl),
        .guess_bus(guess_if.ctrl),
        .next_pulse(next_pulse),
        .score_valid(score_valid),
        .strikes(strikes),
        .balls(balls),
        .score_req(score_req),
        .frame(frame),
        .led(led)
    );

    display_mux #(
        .SCAN_BITS(SCAN_BITS)
    ) u_display (
        .clk(clk),
        .reset(reset),
        .frame(frame),
        .anode(anode),
        .seg(seg)
    );

endmodule

/* design/bulls_pkg.sv */
package bulls_pkg;

    localparam int NUM_DIGITS = 4;
    localparam int NUM_SLOTS = 8;
    localparam int LED_WIDTH = 16;

    typedef logic [3:0] digit_t;
    typedef logic [NUM_DIGITS*4-1:0] code_t;
    typedef logic [1:0] pos_t;
    typedef logic [2:0] count_t;
    typedef logic [3:0] glyph_t;
    typedef logic [NUM_SLOTS*4-1:0] frame_t;
    typedef logic [7:0] seg_t;

    localparam digit_t DIGIT_BLANK = 4'd15;

    // Glyphs 0 to 9 are the digits themselves
    localparam glyph_t GLYPH_BAR = 4'd10;
    localparam glyph_t GLYPH_S = 4'd11;
    localparam glyph_t GLYPH_B = 4'd12;
    localparam glyph_t GLYPH_OFF = 4'd15;

    typedef enum logic [1:0] {
        SECRET,
        GUESS,
        SCORE,
        SHOW
    } game_state_t;

    // Segments a to g then dot, low lights the segment
    function automatic seg_t glyph_to_seg(input glyph_t glyph);
        case (glyph)
            4'd0: return 8'b00000011;
            4'd1: return 8'b10011111;
            4'd2: return 8'b00100101;
            4'd3: return 8'b00001101;
            4'd4: return 8'b10011001;
            4'd5: return 8'b01001001;
            4'd6: return 8'b01000001;
            4'd7: return 8'b00011011;
            4'd8: return 8'b00000001;
            4'd9: return 8'b00001001;
            GLYPH_BAR: return 8'b11111101;
            GLYPH_S: return 8'b01001000;
            GLYPH_B: return 8'b00000000;
            default: return 8'b11111111;
        endcase
    endfunction

endpackage

/* design/button_edge.sv */
`timescale 1ns/10ps

module button_edge (
    input logic clk,
    input logic reset,
    input logic btn_inc,
    input logic btn_next,
    output logic inc_pulse,
    output logic next_pulse
);

    logic [1:0] btn_q;
    logic [1:0] btn_prev;
    logic [1:0] pulse_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            btn_q <= '0;
            btn_prev <= '0;
            pulse_q <= '0;
        end else begin
            btn_q <= {btn_next, btn_inc};
            btn_prev <= btn_q;
            // One pulse per press, however long it is held
            pulse_q <= btn_q & ~btn_prev;
        end
    end

    assign inc_pulse = pulse_q[0];
    assign next_pulse = pulse_q[1];

endmodule

/* design/code_entry.sv */
`timescale 1ns/10ps

module code_entry (
    input logic clk,
    input logic reset,
    input logic inc_pulse,
    input logic next_pulse,
    entry_if.entry bus
);
    import bulls_pkg::*;

    digit_t digits [NUM_DIGITS];
    pos_t cursor_q;
    logic done_q;
    logic all_differ;

    // Blank steps to 1, then 1 through 9, then 0, then back to 1
    function automatic digit_t step_digit(input digit_t d);
        if (d == DIGIT_BLANK || d == 4'd0) begin
            return 4'd1;
        end else if (d == 4'd9) begin
            return 4'd0;
        end else begin
            return d + 4'd1;
        end
    endfunction

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NUM_DIGITS; i++) begin
                digits[i] <= DIGIT_BLANK;
            end
            cursor_q <= '0;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (bus.clear) begin
                for (int i = 0; i < NUM_DIGITS; i++) begin
                    digits[i] <= DIGIT_BLANK;
                end
                cursor_q <= '0;
            end else if (bus.active && inc_pulse) begin
                digits[cursor_q] <= step_digit(digits[cursor_q]);
            end else if (bus.active && next_pulse) begin
                if (cursor_q == pos_t'(NUM_DIGITS - 1)) begin
                    cursor_q <= '0;
                    done_q <= 1'b1;
                end else begin
                    cursor_q <= cursor_q + pos_t'(1);
                end
            end
        end
    end

    // Any blank left over also fails the check
    always_comb begin
        all_differ = 1'b1;
        for (int i = 0; i < NUM_DIGITS; i++) begin
            if (digits[i] == DIGIT_BLANK) begin
                all_differ = 1'b0;
            end
            for (int j = i + 1; j < NUM_DIGITS; j++) begin
                if (digits[i] == digits[j]) begin
                    all_differ = 1'b0;
                end
            end
        end
    end

    // Position 0 goes to the top nibble
    always_comb begin
        for (int i = 0; i < NUM_DIGITS; i++) begin
            bus.code[(NUM_DIGITS-1-i)*4 +: 4] = digits[i];
        end
    end

    assign bus.cursor = cursor_q;
    assign bus.done = done_q;
    assign bus.distinct = all_differ;

endmodule

/* design/display_mux.sv */
`timescale 1ns/10ps

module display_mux #(
    parameter int SCAN_BITS = 20
) (
    input logic clk,
    input logic reset,
    input bulls_pkg::frame_t frame,
    output logic [bulls_pkg::NUM_SLOTS-1:0] anode,
    output bulls_pkg::seg_t seg
);
    import bulls_pkg::*;

    logic [SCAN_BITS-1:0] scan_cnt;
    logic [2:0] sel;
    glyph_t glyph;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            scan_cnt <= '0;
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

    // Top three bits pick the slot, slot 8 first
    assign sel = scan_cnt[SCAN_BITS-1 -: 3];

    // Slot 8 minus sel sits at nibble sel of the frame
    assign glyph = frame[sel*4 +: 4];

    always_comb begin
        for (int i = 0; i < NUM_SLOTS; i++) begin
            anode[i] = (sel != 3'(i));
        end
    end

    assign seg = glyph_to_seg(glyph);

endmodule

/* design/entry_if.sv */
`timescale 1ns/10ps

interface entry_if;
    import bulls_pkg::*;

    // From the controller
    logic active;
    logic clear;

    // From the entry
    code_t code;
    pos_t cursor;
    logic done;
    logic distinct;

    modport entry (
        input active,
        input clear,
        output code,
        output cursor,
        output done,
        output distinct
    );

    modport ctrl (
        output active,
        output clear,
        input code,
        input cursor,
        input done,
        input distinct
    );

endinterface

/* design/game_ctrl.sv */
`timescale 1ns/10ps

module game_ctrl (
    input logic clk,
    input logic reset,
    entry_if.ctrl secret_bus,
    entry_if.ctrl guess_bus,
    input logic next_pulse,
    input logic score_valid,
    input bulls_pkg::count_t strikes,
    input bulls_pkg::count_t balls,
    output logic score_req,
    output bulls_pkg::frame_t frame,
    output logic [bulls_pkg::LED_WIDTH-1:0] led
);
    import bulls_pkg::*;

    game_state_t state;
    game_state_t state_next;
    count_t strikes_q;
    count_t balls_q;
    logic win;
    code_t shown;
    frame_t frame_next;

    assign win = (strikes_q == count_t'(NUM_DIGITS));

    //////////////////////////////////////////////////////////////////////
    // Game sequence
    //////////////////////////////////////////////////////////////////////

    assign secret_bus.active = (state == SECRET);
    assign guess_bus.active = (state == GUESS);

    assign score_req = (state == GUESS) && guess_bus.done && guess_bus.distinct;

    assign secret_bus.clear = ((state == SECRET) && secret_bus.done && !secret_bus.distinct)
                            || ((state == SHOW) && next_pulse && win);

    assign guess_bus.clear = ((state == GUESS) && guess_bus.done && !guess_bus.distinct)
                           || ((state == SHOW) && next_pulse);

    always_comb begin
        state_next = state;
        case (state)
            SECRET: begin
                if (secret_bus.done && secret_bus.distinct) begin
                    state_next = GUESS;
                end
            end
            GUESS: begin
                if (score_req) begin
                    state_next = SCORE;
                end
            end
            SCORE: begin
                if (score_valid) begin
                    state_next = SHOW;
                end
            end
            SHOW: begin
                if (next_pulse) begin
                    state_next = win ? SECRET : GUESS;
                end
            end
            default: state_next = SECRET;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= SECRET;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (state == SCORE && score_valid) begin
            strikes_q <= strikes;
            balls_q <= balls;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Display frame and LEDs
    //////////////////////////////////////////////////////////////////////

    assign shown = (state == SECRET) ? secret_bus.code : guess_bus.code;

    always_comb begin
        for (int i = 0; i < NUM_DIGITS; i++) begin
            if (shown[(NUM_DIGITS-1-i)*4 +: 4] == DIGIT_BLANK) begin
                frame_next[(NUM_SLOTS-1-i)*4 +: 4] = GLYPH_BAR;
            end else begin
                frame_next[(NUM_SLOTS-1-i)*4 +: 4] = shown[(NUM_DIGITS-1-i)*4 +: 4];
            end
        end
        // Slots 5 to 8
        if (state == SHOW) begin
            frame_next[15:12] = glyph_t'({1'b0, strikes_q});
            frame_next[11:8] = GLYPH_S;
            frame_next[7:4] = glyph_t'({1'b0, balls_q});
            frame_next[3:0] = GLYPH_B;
        end else begin
            frame_next[15:0] = {4{GLYPH_OFF}};
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            frame <= {{4{GLYPH_BAR}}, {4{GLYPH_OFF}}};
            led <= '0;
        end else begin
            frame <= frame_next;
            led <= (state == SECRET) ? '0 : '1;
        end
    end

endmodule

/* design/guess_scorer.sv */
`timescale 1ns/10ps

module guess_scorer (
    input logic clk,
    input logic reset,
    input bulls_pkg::code_t secret,
    input bulls_pkg::code_t guess,
    input logic score_req,
    output logic score_valid,
    output bulls_pkg::count_t strikes,
    output bulls_pkg::count_t balls
);
    import bulls_pkg::*;

    count_t strike_sum;
    count_t hit_sum;

    always_comb begin
        logic found;
        strike_sum = '0;
        hit_sum = '0;
        for (int i = 0; i < NUM_DIGITS; i++) begin
            if (secret[i*4 +: 4] == guess[i*4 +: 4]) begin
                strike_sum = strike_sum + count_t'(1);
            end
            // Secret digit anywhere in the guess
            found = 1'b0;
            for (int j = 0; j < NUM_DIGITS; j++) begin
                if (secret[i*4 +: 4] == guess[j*4 +: 4]) begin
                    found = 1'b1;
                end
            end
            if (found) begin
                hit_sum = hit_sum + count_t'(1);
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            score_valid <= 1'b0;
        end else begin
            score_valid <= score_req;
        end
    end

    always_ff @(posedge clk) begin
        if (score_req) begin
            strikes <= strike_sum;
            balls <= hit_sum - strike_sum;
        end
    end

endmodule

/* filelist.f */
design/bulls_pkg.sv
design/entry_if.sv
design/button_edge.sv
design/code_entry.sv
design/guess_scorer.sv
design/game_ctrl.sv
design/display_mux.sv
design/bulls_cows_top.sv
tests/tb_bulls_cows.sv

/* run_sim.sh */
#!/bin/sh
# Builds and runs the Bulls and Cows testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f filelist.f --top-module tb_bulls_cows \
    -Mdir obj_dir -o sim_bulls_cows
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_bulls_cows > sim.log 2>&1
if [ $? -ne 0 ]; then
    cat sim.log
    echo "Simulation exited with an error"
    exit 1
fi

cat sim.log
if grep -q "^Test passed$" sim.log; then
    exit 0
fi
exit 1

/* tests/tb_bulls_cows.sv */
`timescale 1ns/10ps

module tb_bulls_cows;

    localparam int SCAN_BITS = 3;
    localparam int SCAN_CYCLES = 1 << SCAN_BITS;
    localparam int STEP_ROUNDS = 3;
    localparam int MAX_STEPS = 12;
    localparam int NUM_GUESSES = 20;
    // Worst case for one code is ten steps and a confirm per digit
    localparam int CODE_PRESSES = 4 * 11;
    // Two secrets, the guesses, the repeated guess and the winning guess,
    // plus one continue press after each score
    localparam int MAX_PRESSES = STEP_ROUNDS * MAX_STEPS
                               + (NUM_GUESSES + 4) * CODE_PRESSES + NUM_GUESSES + 1;
    localparam int TIMEOUT_CYCLES = MAX_PRESSES * 10 + 200;
    // Bars in slots 1 to 4, off in slots 5 to 8
    localparam logic [31:0] IDLE_FRAME = 32'hAAAA_FFFF;

    logic clk;
    logic reset;
    logic btn_inc;
    logic btn_next;
    logic [7:0] anode;
    logic [7:0] seg;
    logic [15:0] led;

    logic [3:0] shown [1:8];
    int errors;

    bulls_cows_top #(
        .SCAN_BITS(SCAN_BITS)
    ) i_dut (
        .clk(clk),
        .reset(reset),
        .btn_inc(btn_inc),
        .btn_next(btn_next),
        .anode(anode),
        .seg(seg),
        .led(led)
    );

    always #2 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // Reference models
    //////////////////////////////////////////////////////////////////////

    // Returns strikes in the upper three bits, balls in the lower three
    function automatic logic [5:0] score_ref(input logic [15:0] secret, input logic [15:0] guess);
        int strikes;
        int hits;
        logic found;
        strikes = 0;
        hits = 0;
        for (int i = 0; i < 4; i++) begin
            if (secret[(3-i)*4 +: 4] == guess[(3-i)*4 +: 4]) begin
                strikes++;
            end
            found = 1'b0;
            for (int j = 0; j < 4; j++) begin
                if (secret[(3-i)*4 +: 4] == guess[(3-j)*4 +: 4]) begin
                    found = 1'b1;
                end
            end
            if (found) begin
                hits++;
            end
        end
        return {3'(strikes), 3'(hits - strikes)};
    endfunction

    function automatic logic [3:0] next_digit(input logic [3:0] d);
        if (d == 4'd15 || d == 4'd0) begin
            return 4'd1;
        end
        return (d == 4'd9) ? 4'd0 : d + 4'd1;
    endfunction

    // Active low segments a to g then dot
    function automatic logic [3:0] seg_to_glyph(input logic [7:0] s);
        case (s)
            8'b00000011: return 4'd0;
            8'b10011111: return 4'd1;
            8'b00100101: return 4'd2;
            8'b00001101: return 4'd3;
            8'b10011001: return 4'd4;
            8'b01001001: return 4'd5;
            8'b01000001: return 4'd6;
            8'b00011011: return 4'd7;
            8'b00000001: return 4'd8;
            8'b00001001: return 4'd9;
            8'b11111101: return 4'd10;
            8'b01001000: return 4'd11;
            8'b00000000: return 4'd12;
            8'b11111111: return 4'd15;
            default: return 4'd14;
        endcase
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Stimulus and readback
    //////////////////////////////////////////////////////////////////////

    task automatic press_inc;
        @(negedge clk);
        btn_inc = 1'b1;
        repeat (2) @(negedge clk);
        btn_inc = 1'b0;
        repeat (8) @(negedge clk);
    endtask

    task automatic press_next;
        @(negedge clk);
        btn_next = 1'b1;
        repeat (2) @(negedge clk);
        btn_next = 1'b0;
        repeat (8) @(negedge clk);
    endtask

    // Starts from a blank entry with the cursor on position 0
    task automatic enter_code(input logic [15:0] code);
        logic [3:0] d;
        for (int i = 0; i < 4; i++) begin
            d = code[(3-i)*4 +: 4];
            repeat ((d == 4'd0) ? 10 : int'(d)) press_inc();
            press_next();
        end
    endtask

    task automatic make_distinct_code(output logic [15:0] code);
        logic [9:0] used;
        int d;
        used = '0;
        for (int i = 0; i < 4; i++) begin
            do begin
                d = $urandom_range(0, 9);
            end while (used[d]);
            used[d] = 1'b1;
            code[(3-i)*4 +: 4] = 4'(d);
        end
    endtask

    task automatic read_display;
        int slot;
        for (int k = 1; k <= 8; k++) begin
            shown[k] = 4'd14;
        end
        repeat (SCAN_CYCLES) begin
            @(negedge clk);
            slot = 0;
            for (int a = 0; a < 8; a++) begin
                if (anode[a] === 1'b0) begin
                    slot = (slot == 0) ? 8 - a : -1;
                end
            end
            if (slot <= 0) begin
                $display("Display error: anode %b does not select exactly one digit", anode);
                errors++;
            end else begin
                shown[slot] = seg_to_glyph(seg);
            end
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: expected %0h, actual %0h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_frame(input string name, input logic [31:0] expected);
        read_display();
        for (int k = 1; k <= 8; k++) begin
            check_value($sformatf("%s slot %0d", name, k), expected[(8-k)*4 +: 4], shown[k]);
        end
    endtask

    task automatic apply_reset;
        @(negedge clk);
        reset = 1'b1;
        repeat (4) @(negedge clk);
        reset = 1'b0;
        repeat (2) @(negedge clk);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////////////////////////

    initial begin
        logic [15:0] secret;
        logic [15:0] guess;
        logic [5:0] score;
        logic [3:0] model;
        int n;
        clk = 1'b0;
        reset = 1'b1;
        btn_inc = 1'b0;
        btn_next = 1'b0;
        errors = 0;
        void'($urandom(87));
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        repeat (2) @(negedge clk);

        check_value("reset led", 16'h0000, led);
        check_frame("reset", IDLE_FRAME);

        // At least ten steps in total, so the wrap from 9 to 0 is covered
        model = 4'd15;
        for (int r = 0; r < STEP_ROUNDS; r++) begin
            n = $urandom_range(4, MAX_STEPS);
            repeat (n) begin
                press_inc();
                model = next_digit(model);
            end
            check_frame($sformatf("step round %0d", r), {model, 12'hAAA, 16'hFFFF});
        end
        apply_reset();

        make_distinct_code(secret);
        secret[11:8] = secret[15:12];
        enter_code(secret);
        check_value("repeated secret led", 16'h0000, led);
        check_frame("repeated secret", IDLE_FRAME);

        make_distinct_code(secret);
        enter_code(secret);
        check_value("secret led", 16'hFFFF, led);
        check_frame("secret accepted", IDLE_FRAME);

        for (int g = 0; g < NUM_GUESSES; g++) begin
            do begin
                make_distinct_code(guess);
            end while (guess == secret);
            score = score_ref(secret, guess);
            enter_code(guess);
            check_frame($sformatf("guess %0d", g),
                        {guess, 1'b0, score[5:3], 4'hB, 1'b0, score[2:0], 4'hC});
            press_next();
            check_value($sformatf("guess %0d led", g), 16'hFFFF, led);
            check_frame($sformatf("guess %0d next", g), IDLE_FRAME);
        end

        make_distinct_code(guess);
        guess[3:0] = guess[7:4];
        enter_code(guess);
        check_value("repeated guess led", 16'hFFFF, led);
        check_frame("repeated guess", IDLE_FRAME);

        enter_code(secret);
        check_frame("winning guess", {secret, 16'h4B0C});
        press_next();
        check_value("new secret led", 16'h0000, led);
        check_frame("new secret", IDLE_FRAME);

        $display("Checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Watchdog timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Test failed");
        $finish;
    end

endmodule
